//--- src/boomDisplay_defs.svh
`ifndef BOOM_DISPLAY_DEFS_SVH
`define BOOM_DISPLAY_DEFS_SVH

// ---------------------------------------------------------------------------
// raster geometry
// ---------------------------------------------------------------------------
`define H_ACTIVE      320  // visible pixels per line
`define H_TOTAL       400  // pixels per line incl. blanking
`define H_SYNC_START  336  // first column of hsync pulse
`define H_SYNC_END    368  // first column after hsync pulse

`define V_ACTIVE      240  // visible lines per frame
`define V_TOTAL       262  // lines per frame incl. blanking
`define V_SYNC_START  245  // first line of vsync pulse
`define V_SYNC_END    248  // first line after vsync pulse

// ---------------------------------------------------------------------------
// banner placement and colours
// ---------------------------------------------------------------------------
`define BOOM_X0       82   // left edge of the banner
`define BOOM_Y0       96   // top edge of the banner

`define BOOM_RGB      12'hF40  // orange-red strokes
`define BG_RGB        12'h013  // dark blue backdrop

`endif

//--- src/boomDisplayPkg.sv
package boomDisplayPkg;

  // column within a line, covers the full 400-pixel count
  typedef logic [8:0] pixelX_t;

  // row within the active area only
  typedef logic [7:0] pixelY_t;

  // 4 bits per channel
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // which way a bar runs
  typedef enum logic {
    DIR_H = 1'b0,  // long axis along x
    DIR_V = 1'b1   // long axis along y
  } strokeDir_e;

endpackage

//--- src/scanTiming.sv
`timescale 1ns/1ps
`include "boomDisplay_defs.svh"

module scanTiming import boomDisplayPkg::*; (
  input  logic    clk,
  input  logic    reset,
  output pixelX_t x,
  output pixelY_t y,
  output logic    active,
  output logic    hsyncRaw,
  output logic    vsyncRaw
);

  logic [8:0] hCount;    // column, 0 .. H_TOTAL-1
  logic [8:0] vCount;    // line, 0 .. V_TOTAL-1, too wide for pixelY_t
  logic       lineEnd;
  logic       frameEnd;
  logic       hActive;
  logic       vActive;
  logic       hSyncWin;
  logic       vSyncWin;

  // --------------------------------------------------------------------------
  // raster counters
  // --------------------------------------------------------------------------
  assign lineEnd  = (hCount == 9'(`H_TOTAL - 1));
  assign frameEnd = (vCount == 9'(`V_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      hCount <= '0;
      vCount <= '0;
    end else if (lineEnd) begin
      hCount <= '0;
      if (frameEnd) begin
        vCount <= '0;  // wrap to top of next frame
      end else begin
        vCount <= vCount + 9'd1;
      end
    end else begin
      hCount <= hCount + 9'd1;
    end
  end

  // --------------------------------------------------------------------------
  // area and sync decode
  // --------------------------------------------------------------------------
  assign hActive  = (hCount < 9'(`H_ACTIVE));
  assign vActive  = (vCount < 9'(`V_ACTIVE));
  assign hSyncWin = (hCount >= 9'(`H_SYNC_START)) && (hCount < 9'(`H_SYNC_END));
  assign vSyncWin = (vCount >= 9'(`V_SYNC_START)) && (vCount < 9'(`V_SYNC_END));

  always_ff @(posedge clk) begin
    if (reset) begin
      x        <= '0;
      y        <= '0;
      active   <= 1'b0;
      hsyncRaw <= 1'b0;
      vsyncRaw <= 1'b0;
    end else begin
      x        <= hCount;
      y        <= vCount[7:0];  // only meaningful on active rows
      active   <= hActive && vActive;
      hsyncRaw <= hSyncWin;     // high during pulse, polarity set downstream
      vsyncRaw <= vSyncWin;
    end
  end

  // column counter must wrap before it hits the line length
  hCountBound: assert property (@(posedge clk) disable iff (reset)
    hCount < 9'(`H_TOTAL));

  // the registered coordinate of an active pixel lies in the visible columns
  activeInRange: assert property (@(posedge clk) disable iff (reset)
    active |-> (x < 9'(`H_ACTIVE)));

endmodule

//--- src/boomGlyph.sv
`timescale 1ns/1ps
`include "boomDisplay_defs.svh"

module boomGlyph import boomDisplayPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  pixelX_t x,
  input  pixelY_t y,
  input  logic    active,
  output logic    hit
);

  localparam int FULL_STROKES = 24;
  localparam int BOWL_STROKES = 3;
  localparam int STROKE_COUNT = FULL_STROKES + BOWL_STROKES;
  localparam int FULL_LEN     = 20;

  // --------------------------------------------------------------------------
  // stroke table, offsets relative to BOOM_X0 / BOOM_Y0
  // entries 0..7 horizontal bars, 8..23 vertical bars, 24..26 the B bowl
  // --------------------------------------------------------------------------
  localparam int STROKE_X [STROKE_COUNT] = '{
    126, 126,  93,  93,  60,  60,  27,   4,            // horizontal
    122, 122, 112, 112,  89,  89,  79,  79,            // vertical
     56,  56,  46,  46,  23,  23,   0,   0,
    126, 137, 137                                     // bowl
  };

  localparam int STROKE_Y [STROKE_COUNT] = '{
     42,   0,  42,   0,  42,   0,  42,  42,
     24,   3,  24,   3,  24,   3,  24,   3,
     24,   3,  24,   3,  24,   3,  24,   3,
     21,  24,   6
  };

  localparam int STROKE_LEN [STROKE_COUNT] = '{
    FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN,
    FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN,
    FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN, FULL_LEN,
    12, 17, 17  // middle bar, upper and lower right side of the bowl
  };

  localparam strokeDir_e STROKE_DIR [STROKE_COUNT] = '{
    DIR_H, DIR_H, DIR_H, DIR_H, DIR_H, DIR_H, DIR_H, DIR_H,
    DIR_V, DIR_V, DIR_V, DIR_V, DIR_V, DIR_V, DIR_V, DIR_V,
    DIR_V, DIR_V, DIR_V, DIR_V, DIR_V, DIR_V, DIR_V, DIR_V,
    DIR_H, DIR_V, DIR_V
  };

  logic anyHit;

  // bevelled bar, 5 lanes wide: lanes 0/4 lose 2 px per end, lanes 1/3 lose 1
  function automatic logic strokeHit(
    input pixelX_t    px,
    input pixelY_t    py,
    input int         ox,
    input int         oy,
    input int         len,
    input strokeDir_e dir
  );
    int along;
    int across;
    int inset;
    if (dir == DIR_H) begin
      along  = int'(px) - ox;
      across = int'(py) - oy;
    end else begin
      along  = int'(py) - oy;
      across = int'(px) - ox;
    end
    case (across)
      2:       inset = 0;  // centre lane, full length
      1, 3:    inset = 1;
      default: inset = 2;
    endcase
    return (across >= 0) && (across <= 4) &&
           (along >= inset) && (along <= len - 1 - inset);
  endfunction

  // --------------------------------------------------------------------------
  // hit test
  // --------------------------------------------------------------------------
  always_comb begin
    anyHit = 1'b0;
    for (int i = 0; i < STROKE_COUNT; i++) begin
      anyHit = anyHit | strokeHit(x, y, `BOOM_X0 + STROKE_X[i],
                                  `BOOM_Y0 + STROKE_Y[i], STROKE_LEN[i],
                                  STROKE_DIR[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hit <= 1'b0;
    end else begin
      hit <= anyHit && active;  // blanking coordinates alias onto rows, mask them
    end
  end

  // a blank coordinate can never light a pixel one cycle later
  noHitWhenBlank: assert property (@(posedge clk) disable iff (reset)
    !active |=> !hit);

endmodule

//--- src/pixelCompositor.sv
`timescale 1ns/1ps
`include "boomDisplay_defs.svh"

module pixelCompositor import boomDisplayPkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic gameOver,
  input  logic clear,
  input  logic hit,
  input  logic active,
  input  logic hsyncRaw,
  input  logic vsyncRaw,
  output rgb_t rgb,
  output logic de,
  output logic hsync,
  output logic vsync
);

  logic show;       // banner visible
  logic activeDly;  // active aligned with hit
  logic hsyncDly;
  logic vsyncDly;

  always_ff @(posedge clk) begin
    if (reset) begin
      show <= 1'b0;
    end else if (clear) begin
      show <= 1'b0;  // clear beats a simultaneous gameOver
    end else if (gameOver) begin
      show <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // align timing with the glyph stage, then form the pixel
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      activeDly <= 1'b0;
      hsyncDly  <= 1'b0;
      vsyncDly  <= 1'b0;
      rgb       <= '0;
      de        <= 1'b0;
      hsync     <= 1'b1;
      vsync     <= 1'b1;
    end else begin
      activeDly <= active;
      hsyncDly  <= hsyncRaw;
      vsyncDly  <= vsyncRaw;
      if (!activeDly) begin
        rgb <= '0;                 // black in blanking
      end else if (show && hit) begin
        rgb <= rgb_t'(`BOOM_RGB);
      end else begin
        rgb <= rgb_t'(`BG_RGB);
      end
      de    <= activeDly;
      hsync <= ~hsyncDly;          // sync outputs are active low
      vsync <= ~vsyncDly;
    end
  end

  blackWhenBlank: assert property (@(posedge clk) disable iff (reset)
    !de |-> (rgb == '0));

endmodule

//--- src/boomDisplay.sv
`timescale 1ns/1ps

module boomDisplay import boomDisplayPkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic gameOver,
  input  logic clear,
  output rgb_t rgb,
  output logic de,
  output logic hsync,
  output logic vsync
);

  pixelX_t x;
  pixelY_t y;
  logic    active;
  logic    hsyncRaw;
  logic    vsyncRaw;
  logic    hit;

  // decode: raster position and blanking
  scanTiming u_scanTiming (
    .clk      (clk),
    .reset    (reset),
    .x        (x),
    .y        (y),
    .active   (active),
    .hsyncRaw (hsyncRaw),
    .vsyncRaw (vsyncRaw)
  );

  // execute: stroke test, one cycle
  boomGlyph u_boomGlyph (
    .clk    (clk),
    .reset  (reset),
    .x      (x),
    .y      (y),
    .active (active),
    .hit    (hit)
  );

  // result: colour and output timing
  pixelCompositor u_pixelCompositor (
    .clk      (clk),
    .reset    (reset),
    .gameOver (gameOver),
    .clear    (clear),
    .hit      (hit),
    .active   (active),
    .hsyncRaw (hsyncRaw),
    .vsyncRaw (vsyncRaw),
    .rgb      (rgb),
    .de       (de),
    .hsync    (hsync),
    .vsync    (vsync)
  );

endmodule

//--- bench/boomDisplayTb.sv
`timescale 1ns/1ps
`include "boomDisplay_defs.svh"

module boomDisplayTb;

  localparam int WAIT_LIMIT   = 2 * `H_TOTAL * `V_TOTAL;  // two frames of cycles
  localparam int HSYNC_CYCLES = `H_SYNC_END - `H_SYNC_START;
  localparam int VSYNC_CYCLES = (`V_SYNC_END - `V_SYNC_START) * `H_TOTAL;

  logic        clk;
  logic        reset;
  logic        gameOver;
  logic        clear;
  logic [11:0] rgb;
  logic        de;
  logic        hsync;
  logic        vsync;
  int          errorCount;

  boomDisplay u_boomDisplay (
    .clk      (clk),
    .reset    (reset),
    .gameOver (gameOver),
    .clear    (clear),
    .rgb      (rgb),
    .de       (de),
    .hsync    (hsync),
    .vsync    (vsync)
  );

  always #2 clk = ~clk;

  task automatic failRun();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkEqual(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      errorCount++;
      $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
               $time, name, got, expected);
      failRun();
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("Timeout: %s did not happen within two frames", what);
    failRun();
  endtask

  // ------------------------------------------------------------------------
  // raster tracking, all sampling on the falling edge
  // ------------------------------------------------------------------------
  task automatic waitVsyncFall();
    int  n;
    bit  seenHigh;
    n        = 0;
    seenHigh = 1'b0;
    @(negedge clk);
    while (!(seenHigh && !vsync)) begin
      if (vsync) seenHigh = 1'b1;
      n++;
      if (n > WAIT_LIMIT) reportTimeout("vsync falling edge");
      @(negedge clk);
    end
  endtask

  // returns at column 0 of the next line with de high
  task automatic nextLineStart();
    int n;
    n = 0;
    while (de) begin
      n++;
      if (n > WAIT_LIMIT) reportTimeout("end of de run");
      @(negedge clk);
    end
    while (!de) begin
      n++;
      if (n > WAIT_LIMIT) reportTimeout("start of de run");
      @(negedge clk);
    end
  endtask

  task automatic probePixel(input int col, input int row, input logic [11:0] expected);
    waitVsyncFall();  // next full frame
    for (int r = 0; r <= row; r++) begin
      nextLineStart();
    end
    repeat (col) @(negedge clk);
    checkEqual("de", de, 1);
    checkEqual("rgb", rgb, expected);
  endtask

  task automatic pulseStrobe(input bit setShow, input bit clearShow);
    @(posedge clk);
    gameOver <= setShow;
    clear    <= clearShow;
    @(posedge clk);
    gameOver <= 1'b0;
    clear    <= 1'b0;
  endtask

  // one frame: vsync width, de run lengths, hsync widths, black in blanking
  task automatic checkFrameStructure();
    int n;
    int lowCycles;
    int run;
    int lines;
    int hsLow;
    n         = 0;
    lowCycles = 0;
    run       = 0;
    lines     = 0;
    hsLow     = 0;
    waitVsyncFall();
    while (!vsync) begin
      lowCycles++;
      n++;
      if (n > WAIT_LIMIT) reportTimeout("vsync rising edge");
      @(negedge clk);
    end
    checkEqual("vsync low cycles", lowCycles, VSYNC_CYCLES);
    while (vsync) begin
      if (de) begin
        run++;
      end else begin
        if (run != 0) begin
          checkEqual("de run length", run, `H_ACTIVE);
          lines++;
          run = 0;
        end
        checkEqual("rgb", rgb, 0);  // blanking pixel
      end
      if (!hsync) begin
        hsLow++;
      end else if (hsLow != 0) begin
        checkEqual("hsync low cycles", hsLow, HSYNC_CYCLES);
        hsLow = 0;
      end
      n++;
      if (n > WAIT_LIMIT) reportTimeout("next vsync pulse");
      @(negedge clk);
    end
    checkEqual("active lines", lines, `V_ACTIVE);
  endtask

  task automatic skipLine(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch != "\n" && ch != -1) ch = $fgetc(fd);
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    int          fd;
    int          code;
    bit          done;
    logic [7:0]  op;
    int          col;
    int          row;
    logic [11:0] expRgb;
    clk        = 1'b0;
    reset      = 1'b1;
    gameOver   = 1'b0;
    clear      = 1'b0;
    errorCount = 0;
    done       = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    checkFrameStructure();
    fd = $fopen("bench/boomDisplay_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file bench/boomDisplay_stim.txt");
      failRun();
    end
    while (!done) begin
      code = $fscanf(fd, " %c", op);
      if (code != 1) begin
        done = 1'b1;  // end of file
      end else if (op == "#") begin
        skipLine(fd);
      end else begin
        code = $fscanf(fd, "%d %d %h", col, row, expRgb);
        if (code != 3) begin
          $display("Stimulus record with opcode %c is incomplete", op);
          failRun();
        end
        case (op)
          "S":     pulseStrobe(1'b1, 1'b0);
          "C":     pulseStrobe(1'b0, 1'b1);
          "B":     pulseStrobe(1'b1, 1'b1);
          "P":     probePixel(col, row, expRgb);
          default: begin
            $display("Unknown opcode %c in the stimulus file", op);
            failRun();
          end
        endcase
      end
    end
    $fclose(fd);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      failRun();
    end
  end

endmodule

//--- bench/boomDisplay_stim.txt
# op col row rgb: S gameOver, C clear, B both strobes, P probe pixel
# col and row in decimal, rgb in hex, strobe records carry zeros
P 208 98 013
P 206 120 013
S 0 0 000
P 208 98 F40
P 206 120 F40
P 210 96 F40
P 208 96 013
P 227 96 013
P 83 121 F40
P 83 120 013
P 208 119 F40
P 221 110 F40
P 221 128 F40
P 219 116 F40
P 219 117 013
P 10 10 013
C 0 0 000
P 208 98 013
P 221 128 013
S 0 0 000
B 0 0 000
P 208 98 013

//--- boomDisplay.f
+incdir+src
src/boomDisplayPkg.sv
src/scanTiming.sv
src/boomGlyph.sv
src/pixelCompositor.sv
src/boomDisplay.sv
bench/boomDisplayTb.sv

//--- Bender.yml
package:
  name: boomDisplay

sources:
  - include_dirs:
      - src
    files:
      - src/boomDisplayPkg.sv
      - src/scanTiming.sv
      - src/boomGlyph.sv
      - src/pixelCompositor.sv
      - src/boomDisplay.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/boomDisplayTb.sv
